// File: common/ds_defs.svh
// Downsizer width macros

`ifndef DS_DEFS_SVH
`define DS_DEFS_SVH

// --------------------------------------------------
// Request fields
// --------------------------------------------------

`define DS_ADDR_W 32
`define DS_ID_W 4

// --------------------------------------------------
// Data beats
// --------------------------------------------------

// Slave side beat, 64-bit bus
`define DS_WIDE_BYTES 8
// Master side beat, 32-bit bus
`define DS_NARROW_BYTES 4

`endif

// File: common/ds_pkg.sv
// Downsizer AXI types

`include "ds_defs.svh"

package ds_pkg;

  // Request fields
  typedef logic [`DS_ADDR_W-1:0] addr_t;
  typedef logic [`DS_ID_W-1:0]   id_t;
  typedef logic [7:0]            len_t;
  typedef logic [2:0]            size_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // Data on both sides
  typedef logic [8*`DS_WIDE_BYTES-1:0]   wide_data_t;
  typedef logic [`DS_WIDE_BYTES-1:0]     wide_strb_t;
  typedef logic [8*`DS_NARROW_BYTES-1:0] narrow_data_t;
  typedef logic [`DS_NARROW_BYTES-1:0]   narrow_strb_t;

  // AW or AR request, 49 bits
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
  } ax_req_t;

  // Clears the low address bits below a beat size
  function automatic addr_t align_addr(addr_t addr, size_t size);
    return addr & ~((addr_t'(1) << size) - addr_t'(1));
  endfunction

endpackage

// File: common/ds_beat_if.sv
// Narrow beat progress link

interface ds_beat_if (
  input logic clk_i
);
  import ds_pkg::*;

  addr_t beat_addr;
  size_t orig_size;
  logic  data_ok;
  logic  word_end;
  logic  last;
  logic  advance;

  // Request converter side
  modport conv (
    output beat_addr,
    output orig_size,
    output data_ok,
    output word_end,
    output last,
    input  advance
  );

  // Data path side
  modport user (
    input  clk_i,
    input  beat_addr,
    input  orig_size,
    input  data_ok,
    input  word_end,
    input  last,
    output advance
  );

endinterface

// File: rtl/ds_ax_convert.sv
// AXI request converter

`include "ds_defs.svh"

module ds_ax_convert (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            accept_i,
  input  ds_pkg::ax_req_t req_i,
  output ds_pkg::ax_req_t mst_req_o,
  output logic            mst_valid_o,
  input  logic            mst_ready_i,
  ds_beat_if.conv         beat
);
  import ds_pkg::*;

  localparam int unsigned narrow_shift = $clog2(`DS_NARROW_BYTES);
  // Wide lane bits above the narrow lanes
  localparam addr_t lane_mask = addr_t'(`DS_WIDE_BYTES - `DS_NARROW_BYTES);

  logic        downsize;
  logic [15:0] ratio;
  logic [15:0] adj;
  logic [15:0] full_len;
  ax_req_t     conv_req;

  ax_req_t req_q;
  size_t   orig_size_q;
  addr_t   addr_q;
  addr_t   next_addr;
  len_t    cnt_q;
  logic    valid_q;
  logic    data_ok_q;

  // --------------------------------------------------
  // Downsize rule
  // --------------------------------------------------

  always_comb begin
    downsize = (req_i.burst == BURST_INCR) && (req_i.size > size_t'(narrow_shift));
    ratio    = 16'((32'd1 << req_i.size) >> narrow_shift);
    adj      = 16'((req_i.addr & ((addr_t'(1) << req_i.size) - addr_t'(1)) & lane_mask)
                   >> narrow_shift);
    full_len = (16'(req_i.len) + 16'd1) * ratio - adj - 16'd1;
    conv_req = req_i;
    if (downsize) begin
      conv_req.len  = full_len[7:0];
      conv_req.size = size_t'(narrow_shift);
    end
  end

  // --------------------------------------------------
  // Request and beat state
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      data_ok_q <= 1'b0;
    end else if (accept_i) begin
      valid_q   <= 1'b1;
      data_ok_q <= 1'b0;
    end else if (valid_q && mst_ready_i) begin
      valid_q   <= 1'b0;
      data_ok_q <= 1'b1;
    end else if (beat.advance && beat.last) begin
      data_ok_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      req_q       <= conv_req;
      orig_size_q <= req_i.size;
      addr_q      <= req_i.addr;
      cnt_q       <= conv_req.len;
    end else if (beat.advance) begin
      cnt_q <= cnt_q - 8'd1;
      // Fixed bursts keep their address
      if (req_q.burst != BURST_FIXED) begin
        addr_q <= next_addr;
      end
    end
  end

  // Next narrow beat address
  assign next_addr = align_addr(addr_q, req_q.size) + (addr_t'(1) << req_q.size);

  assign mst_req_o      = req_q;
  assign mst_valid_o    = valid_q;
  assign beat.beat_addr = addr_q;
  assign beat.orig_size = orig_size_q;
  assign beat.data_ok   = data_ok_q;
  assign beat.last      = (cnt_q == '0);
  // A wide beat ends where the original beat alignment changes
  assign beat.word_end  = beat.last ||
                          (align_addr(next_addr, orig_size_q) != align_addr(addr_q, orig_size_q));

  // Longer bursts would need splitting
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept_i && downsize |-> full_len <= 16'd255)
    else $error("downsized burst longer than 256 beats");

endmodule

// File: rtl/ds_ctrl.sv
// Request state machines

module ds_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic slv_aw_valid_i,
  input  logic slv_ar_valid_i,
  output logic slv_aw_ready_o,
  output logic slv_ar_ready_o,
  output logic aw_accept_o,
  output logic ar_accept_o,
  input  logic mst_aw_hs_i,
  input  logic mst_ar_hs_i,
  input  logic w_done_i,
  input  logic r_done_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_DATA
  } state_e;

  // Bit 0 is the write side, bit 1 the read side
  logic [1:0] req_valid;
  logic [1:0] ready;
  logic [1:0] accept;
  logic [1:0] hs;
  logic [1:0] done;

  assign req_valid = {slv_ar_valid_i, slv_aw_valid_i};
  assign hs        = {mst_ar_hs_i, mst_aw_hs_i};
  assign done      = {r_done_i, w_done_i};

  assign {slv_ar_ready_o, slv_aw_ready_o} = ready;
  assign {ar_accept_o, aw_accept_o}       = accept;

  // --------------------------------------------------
  // One machine per direction
  // --------------------------------------------------

  for (genvar g = 0; g < 2; g++) begin : gen_dir
    state_e state_q;
    state_e state_d;

    assign ready[g]  = (state_q == ST_IDLE);
    assign accept[g] = ready[g] & req_valid[g];

    always_comb begin
      state_d = state_q;
      unique case (state_q)
        ST_IDLE:  if (accept[g]) state_d = ST_ISSUE;
        // Wait for the narrow side request handshake
        ST_ISSUE: if (hs[g]) state_d = ST_DATA;
        ST_DATA:  if (done[g]) state_d = ST_IDLE;
        default:  state_d = ST_IDLE;
      endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        state_q <= ST_IDLE;
      end else begin
        state_q <= state_d;
      end
    end

    // Converter and data path must follow this machine
    assert property (@(posedge clk_i) disable iff (!rst_ni) hs[g] |-> state_q == ST_ISSUE)
      else $error("request handshake outside ISSUE");
    assert property (@(posedge clk_i) disable iff (!rst_ni) done[g] |-> state_q == ST_DATA)
      else $error("data done outside DATA");
  end

endmodule

// File: rtl/ds_w_steer.sv
// Write data lane steering

`include "ds_defs.svh"

module ds_w_steer (
  input  ds_pkg::wide_data_t   slv_w_data_i,
  input  ds_pkg::wide_strb_t   slv_w_strb_i,
  input  logic                 slv_w_last_i,
  input  logic                 slv_w_valid_i,
  output logic                 slv_w_ready_o,
  output ds_pkg::narrow_data_t mst_w_data_o,
  output ds_pkg::narrow_strb_t mst_w_strb_o,
  output logic                 mst_w_last_o,
  output logic                 mst_w_valid_o,
  input  logic                 mst_w_ready_i,
  output logic                 w_done_o,
  ds_beat_if.user              beat
);
  import ds_pkg::*;

  localparam int unsigned narrow_shift = $clog2(`DS_NARROW_BYTES);
  localparam int unsigned wide_shift   = $clog2(`DS_WIDE_BYTES);

  logic [wide_shift-narrow_shift-1:0] word_idx;
  addr_t                              lane_addr;
  narrow_strb_t                       lane_mask;

  // Narrow word within the wide beat
  assign word_idx = beat.beat_addr[wide_shift-1:narrow_shift];

  // Keep only lanes inside the original beat
  always_comb begin
    lane_addr = beat.beat_addr;
    for (int unsigned n = 0; n < `DS_NARROW_BYTES; n++) begin
      lane_addr[narrow_shift-1:0] = narrow_shift'(n);
      lane_mask[n] = (align_addr(lane_addr, beat.orig_size) ==
                      align_addr(beat.beat_addr, beat.orig_size));
    end
  end

  assign mst_w_data_o = slv_w_data_i[8*`DS_NARROW_BYTES*word_idx +: 8*`DS_NARROW_BYTES];
  assign mst_w_strb_o = slv_w_strb_i[`DS_NARROW_BYTES*word_idx +: `DS_NARROW_BYTES] & lane_mask;

  // --------------------------------------------------
  // Handshakes
  // --------------------------------------------------

  assign mst_w_valid_o = beat.data_ok & slv_w_valid_i;
  assign mst_w_last_o  = beat.last;
  assign beat.advance  = mst_w_valid_o & mst_w_ready_i;
  // Wide beat taken with its final narrow beat
  assign slv_w_ready_o = beat.advance & beat.word_end;
  assign w_done_o      = beat.advance & beat.last;

  assert property (@(posedge beat.clk_i) slv_w_ready_o |-> slv_w_last_i == beat.last)
    else $error("wide W last does not match burst end");

endmodule

// File: rtl/ds_r_gather.sv
// Read data gathering

`include "ds_defs.svh"

module ds_r_gather (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  ds_pkg::id_t          mst_r_id_i,
  input  ds_pkg::narrow_data_t mst_r_data_i,
  input  ds_pkg::resp_e        mst_r_resp_i,
  input  logic                 mst_r_valid_i,
  output logic                 mst_r_ready_o,
  output ds_pkg::id_t          slv_r_id_o,
  output ds_pkg::wide_data_t   slv_r_data_o,
  output ds_pkg::resp_e        slv_r_resp_o,
  output logic                 slv_r_last_o,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i,
  output logic                 r_done_o,
  ds_beat_if.user              beat
);
  import ds_pkg::*;

  localparam int unsigned narrow_shift = $clog2(`DS_NARROW_BYTES);
  localparam int unsigned wide_shift   = $clog2(`DS_WIDE_BYTES);

  logic [wide_shift-narrow_shift-1:0] word_idx;

  logic       valid_q;
  logic       last_q;
  id_t        id_q;
  resp_e      resp_q;
  wide_data_t data_q;

  assign word_idx = beat.beat_addr[wide_shift-1:narrow_shift];

  // --------------------------------------------------
  // Narrow side
  // --------------------------------------------------

  // Stall while a wide beat waits, unless it leaves this cycle
  assign mst_r_ready_o = beat.data_ok & (~valid_q | slv_r_ready_i);
  assign beat.advance  = mst_r_valid_i & mst_r_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (beat.advance) begin
      valid_q <= beat.word_end;
    end else if (slv_r_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Assembled wide beat
  always_ff @(posedge clk_i) begin
    if (beat.advance) begin
      data_q[8*`DS_NARROW_BYTES*word_idx +: 8*`DS_NARROW_BYTES] <= mst_r_data_i;
      id_q   <= mst_r_id_i;
      resp_q <= mst_r_resp_i;
      last_q <= beat.last;
    end
  end

  // --------------------------------------------------
  // Wide side
  // --------------------------------------------------

  assign slv_r_valid_o = valid_q;
  assign slv_r_id_o    = id_q;
  assign slv_r_data_o  = data_q;
  assign slv_r_resp_o  = resp_q;
  assign slv_r_last_o  = last_q;
  assign r_done_o      = valid_q & slv_r_ready_i & last_q;

endmodule

// File: rtl/axi_downsizer.sv
// AXI 64 to 32 bit downsizer

module axi_downsizer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Wide slave port
  input  ds_pkg::id_t          slv_aw_id_i,
  input  ds_pkg::addr_t        slv_aw_addr_i,
  input  ds_pkg::len_t         slv_aw_len_i,
  input  ds_pkg::size_t        slv_aw_size_i,
  input  ds_pkg::burst_e       slv_aw_burst_i,
  input  logic                 slv_aw_valid_i,
  output logic                 slv_aw_ready_o,
  input  ds_pkg::wide_data_t   slv_w_data_i,
  input  ds_pkg::wide_strb_t   slv_w_strb_i,
  input  logic                 slv_w_last_i,
  input  logic                 slv_w_valid_i,
  output logic                 slv_w_ready_o,
  output ds_pkg::id_t          slv_b_id_o,
  output ds_pkg::resp_e        slv_b_resp_o,
  output logic                 slv_b_valid_o,
  input  logic                 slv_b_ready_i,
  input  ds_pkg::id_t          slv_ar_id_i,
  input  ds_pkg::addr_t        slv_ar_addr_i,
  input  ds_pkg::len_t         slv_ar_len_i,
  input  ds_pkg::size_t        slv_ar_size_i,
  input  ds_pkg::burst_e       slv_ar_burst_i,
  input  logic                 slv_ar_valid_i,
  output logic                 slv_ar_ready_o,
  output ds_pkg::id_t          slv_r_id_o,
  output ds_pkg::wide_data_t   slv_r_data_o,
  output ds_pkg::resp_e        slv_r_resp_o,
  output logic                 slv_r_last_o,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i,
  // Narrow master port
  output ds_pkg::id_t          mst_aw_id_o,
  output ds_pkg::addr_t        mst_aw_addr_o,
  output ds_pkg::len_t         mst_aw_len_o,
  output ds_pkg::size_t        mst_aw_size_o,
  output ds_pkg::burst_e       mst_aw_burst_o,
  output logic                 mst_aw_valid_o,
  input  logic                 mst_aw_ready_i,
  output ds_pkg::narrow_data_t mst_w_data_o,
  output ds_pkg::narrow_strb_t mst_w_strb_o,
  output logic                 mst_w_last_o,
  output logic                 mst_w_valid_o,
  input  logic                 mst_w_ready_i,
  input  ds_pkg::id_t          mst_b_id_i,
  input  ds_pkg::resp_e        mst_b_resp_i,
  input  logic                 mst_b_valid_i,
  output logic                 mst_b_ready_o,
  output ds_pkg::id_t          mst_ar_id_o,
  output ds_pkg::addr_t        mst_ar_addr_o,
  output ds_pkg::len_t         mst_ar_len_o,
  output ds_pkg::size_t        mst_ar_size_o,
  output ds_pkg::burst_e       mst_ar_burst_o,
  output logic                 mst_ar_valid_o,
  input  logic                 mst_ar_ready_i,
  input  ds_pkg::id_t          mst_r_id_i,
  input  ds_pkg::narrow_data_t mst_r_data_i,
  input  ds_pkg::resp_e        mst_r_resp_i,
  input  logic                 mst_r_valid_i,
  output logic                 mst_r_ready_o
);
  import ds_pkg::*;

  ax_req_t aw_req;
  ax_req_t ar_req;
  ax_req_t aw_mst_req;
  ax_req_t ar_mst_req;
  logic    aw_accept;
  logic    ar_accept;
  logic    w_done;
  logic    r_done;

  ds_beat_if w_beat (.clk_i(clk_i));
  ds_beat_if r_beat (.clk_i(clk_i));

  // --------------------------------------------------
  // Request channels
  // --------------------------------------------------

  assign aw_req = '{id: slv_aw_id_i, addr: slv_aw_addr_i, len: slv_aw_len_i,
                    size: slv_aw_size_i, burst: slv_aw_burst_i};
  assign ar_req = '{id: slv_ar_id_i, addr: slv_ar_addr_i, len: slv_ar_len_i,
                    size: slv_ar_size_i, burst: slv_ar_burst_i};

  assign mst_aw_id_o    = aw_mst_req.id;
  assign mst_aw_addr_o  = aw_mst_req.addr;
  assign mst_aw_len_o   = aw_mst_req.len;
  assign mst_aw_size_o  = aw_mst_req.size;
  assign mst_aw_burst_o = aw_mst_req.burst;
  assign mst_ar_id_o    = ar_mst_req.id;
  assign mst_ar_addr_o  = ar_mst_req.addr;
  assign mst_ar_len_o   = ar_mst_req.len;
  assign mst_ar_size_o  = ar_mst_req.size;
  assign mst_ar_burst_o = ar_mst_req.burst;

  ds_ctrl u_ctrl (
    .clk_i,
    .rst_ni,
    .slv_aw_valid_i,
    .slv_ar_valid_i,
    .slv_aw_ready_o,
    .slv_ar_ready_o,
    .aw_accept_o    (aw_accept),
    .ar_accept_o    (ar_accept),
    .mst_aw_hs_i    (mst_aw_valid_o & mst_aw_ready_i),
    .mst_ar_hs_i    (mst_ar_valid_o & mst_ar_ready_i),
    .w_done_i       (w_done),
    .r_done_i       (r_done)
  );

  ds_ax_convert u_aw_conv (
    .clk_i,
    .rst_ni,
    .accept_i    (aw_accept),
    .req_i       (aw_req),
    .mst_req_o   (aw_mst_req),
    .mst_valid_o (mst_aw_valid_o),
    .mst_ready_i (mst_aw_ready_i),
    .beat        (w_beat.conv)
  );

  ds_ax_convert u_ar_conv (
    .clk_i,
    .rst_ni,
    .accept_i    (ar_accept),
    .req_i       (ar_req),
    .mst_req_o   (ar_mst_req),
    .mst_valid_o (mst_ar_valid_o),
    .mst_ready_i (mst_ar_ready_i),
    .beat        (r_beat.conv)
  );

  // --------------------------------------------------
  // Data channels
  // --------------------------------------------------

  ds_w_steer u_w_steer (
    .slv_w_data_i,
    .slv_w_strb_i,
    .slv_w_last_i,
    .slv_w_valid_i,
    .slv_w_ready_o,
    .mst_w_data_o,
    .mst_w_strb_o,
    .mst_w_last_o,
    .mst_w_valid_o,
    .mst_w_ready_i,
    .w_done_o      (w_done),
    .beat          (w_beat.user)
  );

  ds_r_gather u_r_gather (
    .clk_i,
    .rst_ni,
    .mst_r_id_i,
    .mst_r_data_i,
    .mst_r_resp_i,
    .mst_r_valid_i,
    .mst_r_ready_o,
    .slv_r_id_o,
    .slv_r_data_o,
    .slv_r_resp_o,
    .slv_r_last_o,
    .slv_r_valid_o,
    .slv_r_ready_i,
    .r_done_o      (r_done),
    .beat          (r_beat.user)
  );

  // B goes straight through
  assign slv_b_id_o    = mst_b_id_i;
  assign slv_b_resp_o  = mst_b_resp_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

// File: bench/tb_narrow_mem.sv
// Narrow AXI memory model

module tb_narrow_mem (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 stall_i,
  input  ds_pkg::id_t          aw_id_i,
  input  ds_pkg::addr_t        aw_addr_i,
  input  ds_pkg::size_t        aw_size_i,
  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  ds_pkg::narrow_data_t w_data_i,
  input  ds_pkg::narrow_strb_t w_strb_i,
  input  logic                 w_last_i,
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  output ds_pkg::id_t          b_id_o,
  output ds_pkg::resp_e        b_resp_o,
  output logic                 b_valid_o,
  input  logic                 b_ready_i,
  input  ds_pkg::id_t          ar_id_i,
  input  ds_pkg::addr_t        ar_addr_i,
  input  ds_pkg::len_t         ar_len_i,
  input  ds_pkg::size_t        ar_size_i,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  output ds_pkg::id_t          r_id_o,
  output ds_pkg::narrow_data_t r_data_o,
  output ds_pkg::resp_e        r_resp_o,
  output logic                 r_valid_o,
  input  logic                 r_ready_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import ds_pkg::*;

  logic [7:0]  mem [0:4095];
  logic [31:0] lfsr;
  addr_t       w_addr;
  addr_t       r_addr;
  size_t       w_size;
  size_t       r_size;
  len_t        r_cnt;
  id_t         w_id;
  logic        w_act;
  logic        w_err;
  logic        r_act;
  logic        r_hold;

  // Galois LFSR, one step per bit
  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'ha300_0000;
    end
    return b;
  endfunction

  function automatic logic ready_bit();
    return stall_i ? rand_bit() : 1'b1;
  endfunction

  // Addresses with bit 12 set answer SLVERR
  initial begin
    lfsr = 32'h600e;
    for (int a = 0; a < 4096; a++) begin
      mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
    end
    w_act = 1'b0;
    r_act = 1'b0;
    aw_ready_o = 1'b0;
    w_ready_o = 1'b0;
    b_valid_o = 1'b0;
    b_id_o = '0;
    b_resp_o = RESP_OKAY;
    ar_ready_o = 1'b0;
    r_valid_o = 1'b0;
    r_id_o = '0;
    r_data_o = '0;
    r_resp_o = RESP_OKAY;
    wait (rst_ni);
    forever begin
      @(posedge clk_i);
      // Sample handshakes of this edge
      if (aw_valid_i && aw_ready_o) begin
        w_addr = aw_addr_i;
        w_size = aw_size_i;
        w_id = aw_id_i;
        w_act = 1'b1;
        w_err = 1'b0;
      end
      if (w_valid_i && w_ready_o) begin
        for (int k = 0; k < 4; k++) begin
          if (w_strb_i[k] && !w_addr[12]) begin
            mem[{w_addr[11:2], 2'b00} + k] = w_data_i[8*k +: 8];
          end
        end
        w_err = w_err | w_addr[12];
        w_addr = (w_addr & ~((addr_t'(1) << w_size) - 1)) + (addr_t'(1) << w_size);
        if (w_last_i) begin
          w_act = 1'b0;
          b_valid_o <= 1'b1;
        end
      end
      if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
      end
      if (ar_valid_i && ar_ready_o) begin
        r_addr = ar_addr_i;
        r_size = ar_size_i;
        r_cnt = ar_len_i;
        r_id_o <= ar_id_i;
        r_act = 1'b1;
      end
      r_hold = r_valid_o && !r_ready_i;
      if (r_valid_o && r_ready_i) begin
        r_addr = (r_addr & ~((addr_t'(1) << r_size) - 1)) + (addr_t'(1) << r_size);
        if (r_cnt == 0) begin
          r_act = 1'b0;
        end else begin
          r_cnt = r_cnt - 1;
        end
      end
      #1;
      aw_ready_o = !w_act && !b_valid_o && ready_bit();
      w_ready_o = w_act && ready_bit();
      b_id_o = w_id;
      b_resp_o = w_err ? RESP_SLVERR : RESP_OKAY;
      ar_ready_o = !r_act && ready_bit();
      if (!r_hold) begin
        r_valid_o = r_act && ready_bit();
      end
      r_data_o = {mem[{r_addr[11:2], 2'b11}], mem[{r_addr[11:2], 2'b10}],
                  mem[{r_addr[11:2], 2'b01}], mem[{r_addr[11:2], 2'b00}]};
      r_resp_o = r_addr[12] ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

// File: bench/tb_axi_downsizer.sv
// AXI downsizer testbench

module tb_axi_downsizer;
  timeunit 1ns;
  timeprecision 100ps;
  import ds_pkg::*;

  logic         clk_i;
  logic         rst_ni;
  logic         stall;
  id_t          slv_aw_id, slv_ar_id, slv_b_id, slv_r_id;
  addr_t        slv_aw_addr, slv_ar_addr;
  len_t         slv_aw_len, slv_ar_len;
  size_t        slv_aw_size, slv_ar_size;
  burst_e       slv_aw_burst, slv_ar_burst;
  logic         slv_aw_valid, slv_aw_ready, slv_ar_valid, slv_ar_ready;
  wide_data_t   slv_w_data, slv_r_data;
  wide_strb_t   slv_w_strb;
  logic         slv_w_last, slv_w_valid, slv_w_ready;
  resp_e        slv_b_resp, slv_r_resp;
  logic         slv_b_valid, slv_b_ready;
  logic         slv_r_last, slv_r_valid, slv_r_ready;
  id_t          mst_aw_id, mst_ar_id, mst_b_id, mst_r_id;
  addr_t        mst_aw_addr, mst_ar_addr;
  len_t         mst_aw_len, mst_ar_len;
  size_t        mst_aw_size, mst_ar_size;
  burst_e       mst_aw_burst, mst_ar_burst;
  logic         mst_aw_valid, mst_aw_ready, mst_ar_valid, mst_ar_ready;
  narrow_data_t mst_w_data, mst_r_data;
  narrow_strb_t mst_w_strb;
  logic         mst_w_last, mst_w_valid, mst_w_ready;
  resp_e        mst_b_resp, mst_r_resp;
  logic         mst_b_valid, mst_b_ready;
  logic         mst_r_valid, mst_r_ready;

  logic [31:0]  lfsr;
  logic [7:0]   ref_mem [addr_t];
  int           mismatches;
  int           failures;
  int           cycles;
  len_t         aw_len_seen, ar_len_seen;
  size_t        aw_size_seen, ar_size_seen;
  burst_e       aw_burst_seen, ar_burst_seen;

  axi_downsizer axi_downsizer_inst (
    .clk_i, .rst_ni,
    .slv_aw_id_i(slv_aw_id), .slv_aw_addr_i(slv_aw_addr), .slv_aw_len_i(slv_aw_len),
    .slv_aw_size_i(slv_aw_size), .slv_aw_burst_i(slv_aw_burst),
    .slv_aw_valid_i(slv_aw_valid), .slv_aw_ready_o(slv_aw_ready),
    .slv_w_data_i(slv_w_data), .slv_w_strb_i(slv_w_strb), .slv_w_last_i(slv_w_last),
    .slv_w_valid_i(slv_w_valid), .slv_w_ready_o(slv_w_ready),
    .slv_b_id_o(slv_b_id), .slv_b_resp_o(slv_b_resp), .slv_b_valid_o(slv_b_valid),
    .slv_b_ready_i(slv_b_ready),
    .slv_ar_id_i(slv_ar_id), .slv_ar_addr_i(slv_ar_addr), .slv_ar_len_i(slv_ar_len),
    .slv_ar_size_i(slv_ar_size), .slv_ar_burst_i(slv_ar_burst),
    .slv_ar_valid_i(slv_ar_valid), .slv_ar_ready_o(slv_ar_ready),
    .slv_r_id_o(slv_r_id), .slv_r_data_o(slv_r_data), .slv_r_resp_o(slv_r_resp),
    .slv_r_last_o(slv_r_last), .slv_r_valid_o(slv_r_valid), .slv_r_ready_i(slv_r_ready),
    .mst_aw_id_o(mst_aw_id), .mst_aw_addr_o(mst_aw_addr), .mst_aw_len_o(mst_aw_len),
    .mst_aw_size_o(mst_aw_size), .mst_aw_burst_o(mst_aw_burst),
    .mst_aw_valid_o(mst_aw_valid), .mst_aw_ready_i(mst_aw_ready),
    .mst_w_data_o(mst_w_data), .mst_w_strb_o(mst_w_strb), .mst_w_last_o(mst_w_last),
    .mst_w_valid_o(mst_w_valid), .mst_w_ready_i(mst_w_ready),
    .mst_b_id_i(mst_b_id), .mst_b_resp_i(mst_b_resp), .mst_b_valid_i(mst_b_valid),
    .mst_b_ready_o(mst_b_ready),
    .mst_ar_id_o(mst_ar_id), .mst_ar_addr_o(mst_ar_addr), .mst_ar_len_o(mst_ar_len),
    .mst_ar_size_o(mst_ar_size), .mst_ar_burst_o(mst_ar_burst),
    .mst_ar_valid_o(mst_ar_valid), .mst_ar_ready_i(mst_ar_ready),
    .mst_r_id_i(mst_r_id), .mst_r_data_i(mst_r_data), .mst_r_resp_i(mst_r_resp),
    .mst_r_valid_i(mst_r_valid), .mst_r_ready_o(mst_r_ready)
  );

  tb_narrow_mem u_mem (
    .clk_i, .rst_ni, .stall_i(stall),
    .aw_id_i(mst_aw_id), .aw_addr_i(mst_aw_addr), .aw_size_i(mst_aw_size),
    .aw_valid_i(mst_aw_valid), .aw_ready_o(mst_aw_ready),
    .w_data_i(mst_w_data), .w_strb_i(mst_w_strb), .w_last_i(mst_w_last),
    .w_valid_i(mst_w_valid), .w_ready_o(mst_w_ready),
    .b_id_o(mst_b_id), .b_resp_o(mst_b_resp), .b_valid_o(mst_b_valid),
    .b_ready_i(mst_b_ready),
    .ar_id_i(mst_ar_id), .ar_addr_i(mst_ar_addr), .ar_len_i(mst_ar_len),
    .ar_size_i(mst_ar_size), .ar_valid_i(mst_ar_valid), .ar_ready_o(mst_ar_ready),
    .r_id_o(mst_r_id), .r_data_o(mst_r_data), .r_resp_o(mst_r_resp),
    .r_valid_o(mst_r_valid), .r_ready_i(mst_r_ready)
  );

  // --------------------------------------------------
  // Clock, timeout and narrow request capture
  // --------------------------------------------------

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (mst_aw_valid && mst_aw_ready) begin
      aw_len_seen <= mst_aw_len;
      aw_size_seen <= mst_aw_size;
      aw_burst_seen <= mst_aw_burst;
    end
    if (mst_ar_valid && mst_ar_ready) begin
      ar_len_seen <= mst_ar_len;
      ar_size_seen <= mst_ar_size;
      ar_burst_seen <= mst_ar_burst;
    end
    if (cycles >= 4000) begin
      $display("timeout: the tests did not finish within 4000 cycles");
      $display("TB FAILED");
      $finish;
    end
  end

  // Galois LFSR for write data and strobes
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic addr_t wide_beat_addr(addr_t addr, size_t size, int i);
    addr_t base;
    base = addr & ~((addr_t'(1) << size) - 1);
    return (i == 0) ? addr : base + (addr_t'(i) << size);
  endfunction

  // Memory decodes twelve address bits
  // Unwritten bytes keep the memory fill pattern
  function automatic logic [7:0] expected_byte(addr_t a);
    addr_t idx;
    idx = a & 32'h0000_0fff;
    if (ref_mem.exists(idx)) begin
      return ref_mem[idx];
    end
    return 8'(idx) ^ 8'(idx >> 8) ^ 8'h5a;
  endfunction

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  // --------------------------------------------------
  // Directed transfers
  // --------------------------------------------------

  task automatic write_burst(id_t id, addr_t addr, len_t len, size_t size,
                             logic rand_strb, len_t exp_len);
    addr_t ba;
    int    lo;
    int    hi;
    @(posedge clk_i);
    #1;
    slv_aw_id = id;
    slv_aw_addr = addr;
    slv_aw_len = len;
    slv_aw_size = size;
    slv_aw_burst = BURST_INCR;
    slv_aw_valid = 1'b1;
    do @(posedge clk_i); while (!slv_aw_ready);
    #1;
    slv_aw_valid = 1'b0;
    for (int i = 0; i <= len; i++) begin
      ba = wide_beat_addr(addr, size, i);
      lo = ba[2:0];
      hi = int'((ba & ~((addr_t'(1) << size) - 1)) % 8) + (1 << size) - 1;
      slv_w_data = rand_bits(64);
      slv_w_strb = '0;
      for (int b = lo; b <= hi; b++) begin
        slv_w_strb[b] = rand_strb ? rand_bits(1) : 1'b1;
        if (slv_w_strb[b]) begin
          ref_mem[{ba[31:3], 3'b000} + b] = slv_w_data[8*b +: 8];
        end
      end
      slv_w_last = (i == len);
      slv_w_valid = 1'b1;
      do @(posedge clk_i); while (!slv_w_ready);
      #1;
    end
    slv_w_valid = 1'b0;
    slv_b_ready = 1'b1;
    do @(posedge clk_i); while (!slv_b_valid);
    check_value("slv_b_id", slv_b_id, id);
    check_value("slv_b_resp", slv_b_resp, RESP_OKAY);
    #1;
    slv_b_ready = 1'b0;
    check_value("mst_aw_len", aw_len_seen, exp_len);
    check_value("mst_aw_size", aw_size_seen, (size > 2) ? 2 : size);
    check_value("mst_aw_burst", aw_burst_seen, BURST_INCR);
  endtask

  task automatic read_burst(id_t id, addr_t addr, len_t len, size_t size, len_t exp_len);
    addr_t ba;
    addr_t a;
    int    lo;
    int    hi;
    int    i;
    logic  done;
    @(posedge clk_i);
    #1;
    slv_ar_id = id;
    slv_ar_addr = addr;
    slv_ar_len = len;
    slv_ar_size = size;
    slv_ar_burst = BURST_INCR;
    slv_ar_valid = 1'b1;
    do @(posedge clk_i); while (!slv_ar_ready);
    #1;
    slv_ar_valid = 1'b0;
    slv_r_ready = 1'b1;
    i = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      if (slv_r_valid) begin
        ba = wide_beat_addr(addr, size, i);
        lo = ba[2:0];
        hi = int'((ba & ~((addr_t'(1) << size) - 1)) % 8) + (1 << size) - 1;
        check_value("slv_r_id", slv_r_id, id);
        check_value("slv_r_last", slv_r_last, i == len);
        check_value("slv_r_resp", slv_r_resp, ba[12] ? RESP_SLVERR : RESP_OKAY);
        for (int b = lo; b <= hi; b++) begin
          a = {ba[31:3], 3'b000} + b;
          check_value($sformatf("slv_r_data[%h]", a), slv_r_data[8*b +: 8], expected_byte(a));
        end
        done = slv_r_last || (i == len);
        i++;
      end
    end
    #1;
    slv_r_ready = 1'b0;
    if (i != int'(len) + 1) begin
      $display("read burst ended after %0d wide beats instead of %0d", i, int'(len) + 1);
      failures++;
    end
    check_value("mst_ar_len", ar_len_seen, exp_len);
    check_value("mst_ar_size", ar_size_seen, (size > 2) ? 2 : size);
    check_value("mst_ar_burst", ar_burst_seen, BURST_INCR);
  endtask

  task automatic check_after_reset();
    check_value("slv_aw_ready", slv_aw_ready, 1'b1);
    check_value("slv_ar_ready", slv_ar_ready, 1'b1);
    check_value("slv_b_valid", slv_b_valid, 1'b0);
    check_value("slv_r_valid", slv_r_valid, 1'b0);
    check_value("mst_aw_valid", mst_aw_valid, 1'b0);
    check_value("mst_ar_valid", mst_ar_valid, 1'b0);
    check_value("mst_w_valid", mst_w_valid, 1'b0);
    check_value("mst_r_ready", mst_r_ready, 1'b0);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    lfsr = 32'h600e;
    mismatches = 0;
    failures = 0;
    cycles = 0;
    stall = 1'b0;
    rst_ni = 1'b0;
    {slv_aw_id, slv_aw_addr, slv_aw_len, slv_aw_size, slv_aw_valid} = '0;
    {slv_ar_id, slv_ar_addr, slv_ar_len, slv_ar_size, slv_ar_valid} = '0;
    slv_aw_burst = BURST_INCR;
    slv_ar_burst = BURST_INCR;
    {slv_w_data, slv_w_strb, slv_w_last, slv_w_valid} = '0;
    slv_b_ready = 1'b0;
    slv_r_ready = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_after_reset();
    // Narrow, aligned, unaligned with strobes
    write_burst(4'h1, 32'h0000_0104, 8'd0, 3'd2, 1'b0, 8'd0);
    read_burst(4'h2, 32'h0000_0104, 8'd0, 3'd2, 8'd0);
    write_burst(4'h3, 32'h0000_0200, 8'd3, 3'd3, 1'b0, 8'd7);
    read_burst(4'h3, 32'h0000_0200, 8'd3, 3'd3, 8'd7);
    write_burst(4'h4, 32'h0000_0304, 8'd3, 3'd3, 1'b1, 8'd6);
    read_burst(4'h4, 32'h0000_0304, 8'd3, 3'd3, 8'd6);
    // Memory stalls on ready and valid
    stall = 1'b1;
    write_burst(4'h6, 32'h0000_0400, 8'd15, 3'd3, 1'b0, 8'd31);
    read_burst(4'h7, 32'h0000_0400, 8'd15, 3'd3, 8'd31);
    stall = 1'b0;
    // Id and response, second beat in the error region
    write_burst(4'h5, 32'h0000_0500, 8'd1, 3'd3, 1'b0, 8'd3);
    read_burst(4'h9, 32'h0000_0ff8, 8'd1, 3'd3, 8'd3);
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+common
common/ds_pkg.sv
common/ds_beat_if.sv
rtl/ds_ax_convert.sv
rtl/ds_ctrl.sv
rtl/ds_w_steer.sv
rtl/ds_r_gather.sv
rtl/axi_downsizer.sv
bench/tb_narrow_mem.sv
bench/tb_axi_downsizer.sv

// File: Bender.yml
package:
  name: axi_downsizer

sources:
  - include_dirs:
      - common
    files:
      - common/ds_pkg.sv
      - common/ds_beat_if.sv
      - rtl/ds_ax_convert.sv
      - rtl/ds_ctrl.sv
      - rtl/ds_w_steer.sv
      - rtl/ds_r_gather.sv
      - rtl/axi_downsizer.sv
  - target: test
    files:
      - bench/tb_narrow_mem.sv
      - bench/tb_axi_downsizer.sv
